// File: tb.f
isa_pkg.sv
ctrl_pkg.sv
core_ctrl_if.sv
control_fsm.sv
program_counter.sv
register_bank.sv
execute_unit.sv
data_ram.sv
cpu.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_cpu -o sim_cpu
./obj_dir/sim_cpu | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
echo "Simulation failed"
exit 1

// File: tb_cpu.sv
module tb_cpu;
    import isa_pkg::*;

    localparam int period = 40;

    logic       clock;
    logic       arst_n;
    logic       enable;
    word_t      imem_addr;
    word_t      imem_data;
    logic [5:0] led;
    logic       wb_valid;
    reg_addr_t  wb_reg;
    word_t      wb_value;

    word_t      prog [64];        // Instruction ROM served to the core
    int         n_instr;
    word_t      model_mem [64];
    logic [5:0] model_led;
    reg_addr_t  exp_reg [$];
    word_t      exp_val [$];
    word_t      exp_pc [$];       // Fetch addresses in execution order
    int         errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    time        deadline = 0;

    cpu dut_i (.*);

    assign imem_data = prog[imem_addr[7:2]];

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    // Each test moves the watchdog deadline forward
    initial begin
        while ($time <= deadline) @(posedge clock);
        $display("Timeout at time %0t, the program never reached its final address", $time);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected %h, actual %h", $time, name, expected,
                     actual);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t expected,
                             input reg_addr_t actual);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected x%0d, actual x%0d", $time, name,
                     expected, actual);
            errors++;
        end
    endtask

    task automatic check_led(input string name, input logic [5:0] expected,
                             input logic [5:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected %h, actual %h", $time, name, expected,
                     actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected %b, actual %b", $time, name, expected,
                     actual);
            errors++;
        end
    endtask

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, f3_word, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    task automatic clear_prog();
        for (int i = 0; i < 64; i++) begin
            prog[i] = '0;
        end
        n_instr = 0;
    endtask

    task automatic emit(input word_t instr);
        prog[n_instr] = instr;
        n_instr++;
    endtask

    // Instruction-level model of the subset that fills the expected queues
    task automatic run_model(output int steps);
        word_t r [32];
        word_t pc;
        word_t ins;
        word_t a;
        word_t b;
        word_t val;
        word_t addr;
        word_t pc_next;
        logic  wr;
        r = '{default: '0};
        pc = '0;
        steps = 0;
        model_led = '0;
        exp_reg.delete();
        exp_val.delete();
        exp_pc.delete();
        while (pc != 4 * n_instr && steps < 200) begin
            ins = prog[pc[7:2]];
            exp_pc.push_back(pc);
            a = r[ins[19:15]];
            b = r[ins[24:20]];
            wr = 1'b1;
            val = '0;
            pc_next = pc + 32'd4;
            case (ins[6:0])
                op_reg: begin
                    case ({ins[31:25], ins[14:12]})
                        {f7_base, f3_add_sub}: val = a + b;
                        {f7_sub, f3_add_sub}:  val = a - b;
                        {f7_base, f3_slt}:     val = {31'b0, $signed(a) < $signed(b)};
                        {f7_base, f3_xor}:     val = a ^ b;
                        {f7_base, f3_or}:      val = a | b;
                        {f7_base, f3_and}:     val = a & b;
                        default:               wr = 1'b0;
                    endcase
                end
                op_imm: begin
                    val = a + {{20{ins[31]}}, ins[31:20]};
                    wr = (ins[14:12] == f3_add_sub);
                end
                op_lui: val = {ins[31:12], 12'b0};
                op_load: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    val = model_mem[addr[7:2]];   // Upper bits wrap
                    wr = (ins[14:12] == f3_word);
                end
                op_store: begin
                    wr = 1'b0;
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    if (ins[14:12] == f3_word) begin
                        model_mem[addr[7:2]] = b;
                        model_led = b[5:0];
                    end
                end
                op_branch: begin
                    wr = 1'b0;
                    if ((ins[14:12] == f3_beq && a == b) ||
                        (ins[14:12] == f3_bne && a != b)) begin
                        pc_next = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8],
                                        1'b0};
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                r[ins[11:7]] = val;
                exp_reg.push_back(ins[11:7]);
                exp_val.push_back(val);
            end
            pc = pc_next;
            steps++;
        end
        exp_pc.push_back(pc);   // End address that stops the run
    endtask

    task automatic apply_reset();
        @(posedge clock);
        #2;
        arst_n = 1'b0;
        enable = 1'b1;
        repeat (3) @(posedge clock);
        #2;
        arst_n = 1'b1;
        @(negedge clock);
    endtask

    task automatic run_program(input string name, input logic stall);
        int    steps;
        int    start_errors;
        int    hold;
        int    spans;
        logic  frozen;
        word_t last_pc;
        start_errors = errors;
        run_model(steps);
        deadline = $time + time'((5 * steps + 40) * period);   // Stalls and reset included
        apply_reset();
        check_word("imem_addr", '0, imem_addr);
        check_flag("wb_valid", 1'b0, wb_valid);
        check_led("led", '0, led);
        last_pc = imem_addr;
        check_word("imem_addr", exp_pc.pop_front(), imem_addr);
        hold = 0;
        spans = 0;
        while (last_pc != 4 * n_instr) begin
            @(posedge clock);
            frozen = !enable;
            #2;
            if (hold == 0 && stall && spans < 4 && $urandom_range(7) == 0) begin
                hold = $urandom_range(4, 1);
                spans++;
            end
            enable = (hold == 0);
            if (hold > 0) begin
                hold--;
            end
            @(negedge clock);
            if (frozen) begin
                check_word("imem_addr", last_pc, imem_addr);
            end
            if (!enable) begin
                check_flag("wb_valid", 1'b0, wb_valid);
            end else if (wb_valid) begin
                if (exp_reg.size() == 0) begin
                    $display("Unexpected writeback to x%0d at time %0t", wb_reg, $time);
                    errors++;
                end else begin
                    check_reg("wb_reg", exp_reg.pop_front(), wb_reg);
                    check_word("wb_value", exp_val.pop_front(), wb_value);
                end
            end
            if (imem_addr != last_pc) begin
                last_pc = imem_addr;
                if (exp_pc.size() == 0) begin
                    $display("Fetch from %h at time %0t after the program ended", last_pc, $time);
                    errors++;
                end else begin
                    check_word("imem_addr", exp_pc.pop_front(), imem_addr);
                end
            end
        end
        if (exp_reg.size() != 0 || exp_pc.size() != 0) begin
            $display("Program %s ended with %0d writebacks and %0d fetches never seen", name,
                     exp_reg.size(), exp_pc.size());
            errors++;
        end
        check_led("led", model_led, led);
        tests_run++;
        if (errors == start_errors) begin
            $display("Test %s passed, %0d instructions", name, steps);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic test_alu();
        word_t rnd;
        clear_prog();
        for (int i = 1; i <= 2; i++) begin
            rnd = $urandom;
            emit({rnd[31:12], 5'(i), op_lui});
            rnd = $urandom;
            emit(enc_i(rnd[11:0], 5'(i), f3_add_sub, 5'(i), op_imm));
        end
        emit(enc_r(f7_base, 5'd2, 5'd1, f3_add_sub, 5'd3));
        emit(enc_r(f7_sub, 5'd2, 5'd1, f3_add_sub, 5'd4));
        emit(enc_r(f7_base, 5'd2, 5'd1, f3_and, 5'd5));
        emit(enc_r(f7_base, 5'd2, 5'd1, f3_or, 5'd6));
        emit(enc_r(f7_base, 5'd2, 5'd1, f3_xor, 5'd7));
        emit(enc_r(f7_base, 5'd2, 5'd1, f3_slt, 5'd8));
        emit(enc_r(f7_base, 5'd1, 5'd2, f3_slt, 5'd9));
        rnd = $urandom;
        emit(enc_i(rnd[11:0], 5'd3, f3_add_sub, 5'd10, op_imm));
        run_program("alu", 1'b0);
    endtask

    task automatic test_memory();
        word_t rnd;
        clear_prog();
        rnd = $urandom;
        emit(enc_i({4'b0, rnd[7:2], 2'b0}, 5'd0, f3_add_sub, 5'd1, op_imm));   // Base address
        for (int i = 0; i < 3; i++) begin
            rnd = $urandom;
            emit({rnd[31:12], 5'd2, op_lui});
            emit(enc_i(rnd[11:0], 5'd2, f3_add_sub, 5'd2, op_imm));
            emit(enc_s(12'(4 * i), 5'd2, 5'd1));
        end
        emit(enc_i(12'd256, 5'd1, f3_word, 5'd3, op_load));   // Wraps back to word 0
        emit(enc_i(12'd4, 5'd1, f3_word, 5'd4, op_load));
        emit(enc_i(12'hF08, 5'd1, f3_word, 5'd5, op_load));   // Offset -248
        run_program("memory", 1'b0);
    endtask

    task automatic test_branch();
        clear_prog();
        emit(enc_i(12'd5, 5'd0, f3_add_sub, 5'd1, op_imm));
        emit(enc_i(12'd5, 5'd0, f3_add_sub, 5'd2, op_imm));
        emit(enc_i(12'd7, 5'd0, f3_add_sub, 5'd3, op_imm));
        emit(enc_b(13'd8, 5'd2, 5'd1, f3_beq));   // Taken
        emit(enc_i(12'd1, 5'd0, f3_add_sub, 5'd10, op_imm));
        emit(enc_b(13'd8, 5'd3, 5'd1, f3_bne));   // Taken
        emit(enc_i(12'd2, 5'd0, f3_add_sub, 5'd11, op_imm));
        emit(enc_b(13'd8, 5'd3, 5'd1, f3_beq));   // Falls through
        emit(enc_i(12'd3, 5'd0, f3_add_sub, 5'd12, op_imm));
        emit(enc_b(13'd8, 5'd2, 5'd1, f3_bne));   // Falls through
        emit(enc_i(12'd4, 5'd0, f3_add_sub, 5'd13, op_imm));
        run_program("branch", 1'b0);
    endtask

    task automatic test_x0_nop();
        word_t rnd;
        clear_prog();
        emit(enc_i(12'd77, 5'd0, f3_add_sub, 5'd1, op_imm));
        emit(enc_i(12'd123, 5'd0, f3_add_sub, 5'd0, op_imm));
        rnd = $urandom;
        emit({rnd[31:12], 5'd0, op_lui});
        emit(enc_r(f7_base, 5'd1, 5'd1, f3_add_sub, 5'd0));
        emit(enc_r(f7_base, 5'd1, 5'd0, f3_add_sub, 5'd5));   // x0 must still read zero
        emit(32'hFFFF_FFFF);
        emit(enc_i(12'd9, 5'd5, f3_add_sub, 5'd6, op_imm));
        run_program("x0_nop", 1'b0);
    endtask

    task automatic test_enable();
        word_t rnd;
        clear_prog();
        rnd = $urandom;
        emit(enc_i(rnd[11:0], 5'd0, f3_add_sub, 5'd1, op_imm));
        emit({rnd[31:12], 5'd2, op_lui});
        emit(enc_r(f7_base, 5'd2, 5'd1, f3_add_sub, 5'd3));
        emit(enc_s(12'd12, 5'd3, 5'd0));
        emit(enc_i(12'd12, 5'd0, f3_word, 5'd4, op_load));
        emit(enc_b(13'd8, 5'd4, 5'd3, f3_beq));
        emit(enc_i(12'd1, 5'd0, f3_add_sub, 5'd5, op_imm));
        emit(enc_r(f7_sub, 5'd1, 5'd3, f3_add_sub, 5'd6));
        emit(enc_r(f7_base, 5'd3, 5'd1, f3_slt, 5'd7));
        run_program("enable", 1'b1);
    endtask

    initial begin
        arst_n = 1'b0;
        enable = 1'b0;
        clear_prog();
        void'($urandom(42));
        test_alu();
        test_memory();
        test_branch();
        test_x0_nop();
        test_enable();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: cpu.sv
module cpu (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               enable,
    output isa_pkg::word_t     imem_addr,
    input  isa_pkg::word_t     imem_data,
    output logic [5:0]         led,
    output logic               wb_valid,
    output isa_pkg::reg_addr_t wb_reg,
    output isa_pkg::word_t     wb_value
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    core_ctrl_if ctrl_if ();

    word_t pc;
    word_t branch_target;
    word_t rs1_value;
    word_t rs2_value;
    word_t result;      // ALU result, also the RAM address
    word_t read_data;

    control_fsm fsm_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .enable    (enable),
        .imem_data (imem_data),
        .ctrl      (ctrl_if.fsm)
    );

    program_counter pc_i (
        .clock         (clock),
        .arst_n        (arst_n),
        .enable        (enable),
        .ctrl          (ctrl_if.pc),
        .branch_target (branch_target),
        .pc            (pc)
    );

    register_bank regs_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .ctrl        (ctrl_if.regs),
        .write_value (wb_value),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value)
    );

    execute_unit exec_i (
        .clock         (clock),
        .arst_n        (arst_n),
        .ctrl          (ctrl_if.exec),
        .pc            (pc),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .result        (result),
        .branch_target (branch_target)
    );

    data_ram ram_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .ctrl       (ctrl_if.mem),
        .addr       (result),
        .write_data (rs2_value),   // rs2 still held in the instruction register
        .read_data  (read_data),
        .led        (led)
    );

    assign imem_addr = pc;

    // Writeback mux and trace
    assign wb_value = ctrl_if.mem_to_reg ? read_data : result;
    assign wb_reg   = ctrl_if.rd;
    assign wb_valid = ctrl_if.reg_write && (ctrl_if.state == st_writeback);

endmodule

// File: data_ram.sv
module data_ram (
    input  logic            clock,
    input  logic            arst_n,
    core_ctrl_if.mem        ctrl,
    input  isa_pkg::word_t  addr,
    input  isa_pkg::word_t  write_data,
    output isa_pkg::word_t  read_data,
    output logic [5:0]      led
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    word_t                    mem [ram_words];
    logic [ram_addr_bits-1:0] index;

    // Word index, upper address bits ignored so accesses wrap
    assign index = addr[ram_addr_bits+1:2];

    always_ff @(posedge clock) begin
        if (ctrl.mem_write) begin
            mem[index] <= write_data;
        end
        if (ctrl.state == st_memory) begin
            read_data <= mem[index];   // Load data for writeback
        end
    end

    // Low bits of the last stored word
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            led <= '0;
        end else if (ctrl.mem_write) begin
            led <= write_data[5:0];
        end
    end

endmodule

// File: execute_unit.sv
module execute_unit (
    input  logic            clock,
    input  logic            arst_n,
    core_ctrl_if.exec       ctrl,
    input  isa_pkg::word_t  pc,
    input  isa_pkg::word_t  rs1_value,
    input  isa_pkg::word_t  rs2_value,
    output isa_pkg::word_t  result,
    output isa_pkg::word_t  branch_target
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm;
    word_t      op_b;
    word_t      alu_out;

    assign opcode = opcode_e'(ctrl.instr[6:0]);
    assign funct3 = ctrl.instr[14:12];

    assign imm_i = {{20{ctrl.instr[31]}}, ctrl.instr[31:20]};
    assign imm_s = {{20{ctrl.instr[31]}}, ctrl.instr[31:25], ctrl.instr[11:7]};
    assign imm_u = {ctrl.instr[31:12], 12'b0};
    assign imm_b = {{19{ctrl.instr[31]}}, ctrl.instr[31], ctrl.instr[7],
                    ctrl.instr[30:25], ctrl.instr[11:8], 1'b0};

    always_comb begin
        case (opcode)
            op_store:  imm = imm_s;
            op_lui:    imm = imm_u;
            op_branch: imm = imm_b;
            default:   imm = imm_i;   // ADDI and LW
        endcase
    end

    assign op_b = ctrl.use_imm ? imm : rs2_value;

    always_comb begin
        case (ctrl.alu_op)
            alu_sub:    alu_out = rs1_value - op_b;
            alu_and:    alu_out = rs1_value & op_b;
            alu_or:     alu_out = rs1_value | op_b;
            alu_xor:    alu_out = rs1_value ^ op_b;
            alu_slt:    alu_out = {31'b0, $signed(rs1_value) < $signed(op_b)};
            alu_pass_b: alu_out = op_b;
            default:    alu_out = rs1_value + op_b;
        endcase
    end

    // Branch compare works on the raw register values
    assign ctrl.branch_taken = (funct3 == f3_bne) ? (rs1_value != rs2_value)
                                                  : (rs1_value == rs2_value);
    assign branch_target = pc + imm_b;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (ctrl.result_load) begin
            result <= alu_out;
        end
    end

endmodule

// File: register_bank.sv
module register_bank (
    input  logic            clock,
    input  logic            arst_n,
    core_ctrl_if.regs       ctrl,
    input  isa_pkg::word_t  write_value,
    output isa_pkg::word_t  rs1_value,
    output isa_pkg::word_t  rs2_value
);
    import isa_pkg::*;

    word_t     regs [32];
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;

    // Source fields of the held instruction
    assign rs1_addr = ctrl.instr[19:15];
    assign rs2_addr = ctrl.instr[24:20];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write) begin
            regs[ctrl.rd] <= write_value;   // Control never targets x0
        end
    end

    // Combinational read ports
    assign rs1_value = regs[rs1_addr];
    assign rs2_value = regs[rs2_addr];

endmodule

// File: program_counter.sv
module program_counter (
    input  logic            clock,
    input  logic            arst_n,
    input  logic            enable,
    core_ctrl_if.pc         ctrl,
    input  isa_pkg::word_t  branch_target,
    output isa_pkg::word_t  pc
);

    // Branch load wins over increment
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (enable) begin
            if (ctrl.pc_load) begin
                pc <= branch_target;
            end else if (ctrl.pc_inc) begin
                pc <= pc + 32'd4;   // Next word
            end
        end
    end

endmodule

// File: control_fsm.sv
module control_fsm (
    input  logic            clock,
    input  logic            arst_n,
    input  logic            enable,
    input  isa_pkg::word_t  imem_data,
    core_ctrl_if.fsm        ctrl
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    cpu_state_e   state;
    cpu_state_e   state_next;
    word_t        instr;
    instr_class_e cls;
    alu_op_e      alu_op;
    opcode_e      opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    reg_addr_t    rd;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    // Instruction class and ALU operation
    always_comb begin
        cls    = cls_nop;
        alu_op = alu_add;
        case (opcode)
            op_reg: begin
                if (funct7 == f7_base || (funct7 == f7_sub && funct3 == f3_add_sub)) begin
                    cls = cls_alu_reg;
                    case (funct3)
                        f3_add_sub: alu_op = (funct7 == f7_sub) ? alu_sub : alu_add;
                        f3_slt:     alu_op = alu_slt;
                        f3_xor:     alu_op = alu_xor;
                        f3_or:      alu_op = alu_or;
                        f3_and:     alu_op = alu_and;
                        default:    cls = cls_nop;   // Shifts and SLTU
                    endcase
                end
            end
            op_imm: begin
                if (funct3 == f3_add_sub) begin
                    cls = cls_alu_imm;   // ADDI only
                end
            end
            op_lui: begin
                cls    = cls_lui;
                alu_op = alu_pass_b;
            end
            op_load: begin
                if (funct3 == f3_word) begin
                    cls = cls_load;
                end
            end
            op_store: begin
                if (funct3 == f3_word) begin
                    cls = cls_store;
                end
            end
            op_branch: begin
                if (funct3 == f3_beq || funct3 == f3_bne) begin
                    cls    = cls_branch;
                    alu_op = alu_sub;
                end
            end
            default: cls = cls_nop;
        endcase
    end

    // Next state and the strobes of the current state
    always_comb begin
        state_next       = state;
        ctrl.pc_inc      = 1'b0;
        ctrl.pc_load     = 1'b0;
        ctrl.result_load = 1'b0;
        ctrl.mem_write   = 1'b0;
        ctrl.reg_write   = 1'b0;
        if (enable) begin   // Disabled means hold, with no writes
            case (state)
                st_fetch: state_next = st_decode;
                st_decode: begin
                    if (cls == cls_nop) begin
                        ctrl.pc_inc = 1'b1;
                        state_next  = st_fetch;
                    end else begin
                        state_next = st_execute;
                    end
                end
                st_execute: begin
                    ctrl.result_load = 1'b1;
                    if (cls == cls_branch) begin
                        ctrl.pc_load = ctrl.branch_taken;
                        ctrl.pc_inc  = !ctrl.branch_taken;
                        state_next   = st_fetch;
                    end else if (cls == cls_load || cls == cls_store) begin
                        state_next = st_memory;
                    end else begin
                        state_next = st_writeback;
                    end
                end
                st_memory: begin
                    if (cls == cls_store) begin
                        ctrl.mem_write = 1'b1;
                        ctrl.pc_inc    = 1'b1;
                        state_next     = st_fetch;
                    end else begin
                        state_next = st_writeback;
                    end
                end
                st_writeback: begin
                    ctrl.reg_write = (rd != 5'd0);   // x0 stays zero
                    ctrl.pc_inc    = 1'b1;
                    state_next     = st_fetch;
                end
                default: state_next = st_fetch;
            endcase
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_fetch;
            instr <= '0;   // Decodes as a no-op
        end else if (enable) begin
            state <= state_next;
            if (state == st_fetch) begin
                instr <= imem_data;
            end
        end
    end

    assign ctrl.state      = state;
    assign ctrl.instr      = instr;
    assign ctrl.alu_op     = alu_op;
    assign ctrl.use_imm    = (cls inside {cls_alu_imm, cls_lui, cls_load, cls_store});
    assign ctrl.mem_to_reg = (cls == cls_load);
    assign ctrl.rd         = rd;

endmodule

// File: core_ctrl_if.sv
interface core_ctrl_if;
    import isa_pkg::*;
    import ctrl_pkg::*;

    cpu_state_e state;
    word_t      instr;         // Instruction register
    alu_op_e    alu_op;
    logic       use_imm;       // AluSrc
    logic       pc_inc;
    logic       pc_load;       // PCSrc
    logic       result_load;
    logic       mem_write;     // MemWrite
    logic       mem_to_reg;    // MemToReg, also marks MemRead
    logic       reg_write;     // RegWrite, never set for x0
    reg_addr_t  rd;
    logic       branch_taken;

    modport fsm (
        output state, instr, alu_op, use_imm, pc_inc, pc_load,
        output result_load, mem_write, mem_to_reg, reg_write, rd,
        input  branch_taken
    );
    modport pc   (input pc_inc, pc_load);
    modport exec (input instr, alu_op, use_imm, result_load, output branch_taken);
    modport mem  (input mem_write, state);
    modport regs (input instr, reg_write, rd, mem_to_reg);

endinterface

// File: ctrl_pkg.sv
package ctrl_pkg;

    // Multicycle FSM states, one per classic stage
    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } cpu_state_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b   // LUI passes the U immediate through
    } alu_op_e;

    // Decides the state sequence of an instruction
    typedef enum logic [2:0] {
        cls_alu_reg,
        cls_alu_imm,
        cls_lui,
        cls_load,
        cls_store,
        cls_branch,
        cls_nop      // Anything outside the subset
    } instr_class_e;

endpackage

// File: isa_pkg.sv
package isa_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;   // Data, addresses and instructions
    typedef logic [4:0]      reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    // funct3 values
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_word    = 3'b010;   // LW and SW

    // funct7 values
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    // Data RAM geometry
    localparam int ram_words     = 64;
    localparam int ram_addr_bits = 6;

endpackage
